// ==== include/cc_route_consts.svh ====
// Core complex routing fabric constants
// Widths, port counts and queue depths shared by all blocks
`ifndef CC_ROUTE_CONSTS_SVH
`define CC_ROUTE_CONSTS_SVH

// Data path widths
`define CC_ADDR_WIDTH 32
`define CC_DATA_WIDTH 32

// Offload destination register id
`define CC_ID_WIDTH 5

// Accelerator ports and select bits from the offload address
`define CC_NUM_ACC 4
`define CC_ACC_SEL_WIDTH 2

// Low address bits inside the TCDM window
`define CC_TCDM_ADDR_WIDTH 17

// Outstanding data requests
`define CC_RESP_DEPTH 4

`endif

// ==== logic/cc_offload_pkg.sv ====
// Offload path types
// Request and response payloads between core and accelerator ports
`include "cc_route_consts.svh"

package cc_offload_pkg;

  // --------------------------------------------------
  // Offload request
  // --------------------------------------------------
  typedef struct packed {
    // Low bits select the accelerator port
    logic [`CC_ACC_SEL_WIDTH-1:0] addr;
    logic [`CC_ID_WIDTH-1:0]      id;
    logic [`CC_DATA_WIDTH-1:0]    data_arga;
    logic [`CC_DATA_WIDTH-1:0]    data_op;
  } acc_req_t;

  // --------------------------------------------------
  // Offload response
  // --------------------------------------------------
  typedef struct packed {
    logic [`CC_ID_WIDTH-1:0]   id;
    logic [`CC_DATA_WIDTH-1:0] data;
    logic                      error;
  } acc_rsp_t;

endpackage

// ==== logic/cc_mem_pkg.sv ====
// Data path types
// Data request and response payloads and the target port select
`include "cc_route_consts.svh"

package cc_mem_pkg;

  // --------------------------------------------------
  // Data request
  // --------------------------------------------------
  typedef struct packed {
    logic [`CC_ADDR_WIDTH-1:0]   addr;
    logic                        write;
    logic [`CC_DATA_WIDTH-1:0]   data;
    logic [`CC_DATA_WIDTH/8-1:0] strb;
  } dreq_t;

  // --------------------------------------------------
  // Data response
  // --------------------------------------------------
  typedef struct packed {
    logic [`CC_DATA_WIDTH-1:0] data;
    logic                      error;
  } drsp_t;

  // Target of a data access
  typedef enum logic {
    PORT_SOC  = 1'b0,
    PORT_TCDM = 1'b1
  } port_sel_e;

endpackage

// ==== logic/offload_demux.sv ====
// Offload request demux
// Steers the core offload stream to one of the accelerator ports
`timescale 1ns/1ps
`include "cc_route_consts.svh"

module offload_demux (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Core side
  input  logic                           acc_qvalid_i,
  input  cc_offload_pkg::acc_req_t       acc_qreq_i,
  output logic                           acc_qready_o,
  // Accelerator side
  output logic [`CC_NUM_ACC-1:0]         acc_port_qvalid_o,
  output cc_offload_pkg::acc_req_t       acc_port_qreq_o,
  input  logic [`CC_NUM_ACC-1:0]         acc_port_qready_i
);

  // One-hot valid on the addressed port
  always_comb begin
    acc_port_qvalid_o = '0;
    acc_port_qvalid_o[acc_qreq_i.addr] = acc_qvalid_i;
  end

  // Only the selected port may accept
  assign acc_qready_o = acc_port_qready_i[acc_qreq_i.addr];

  // Payload is broadcast, valid qualifies it
  assign acc_port_qreq_o = acc_qreq_i;

endmodule

// ==== logic/offload_rsp_arbiter.sv ====
// Offload response arbiter
// Round-robin merge of the accelerator response streams into one
`timescale 1ns/1ps
`include "cc_route_consts.svh"

module offload_rsp_arbiter (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Accelerator side
  input  logic [`CC_NUM_ACC-1:0]                     acc_port_pvalid_i,
  input  cc_offload_pkg::acc_rsp_t [`CC_NUM_ACC-1:0] acc_port_prsp_i,
  output logic [`CC_NUM_ACC-1:0]                     acc_port_pready_o,
  // Core side
  output logic                                       acc_pvalid_o,
  output cc_offload_pkg::acc_rsp_t                   acc_prsp_o,
  input  logic                                       acc_pready_i
);

  localparam int unsigned SelW = `CC_ACC_SEL_WIDTH;

  logic [SelW-1:0] last_q;
  logic [SelW-1:0] gnt_q;
  logic            lock_q;
  logic [SelW-1:0] sel;
  logic            found;

  // --------------------------------------------------
  // Grant selection
  // --------------------------------------------------
  always_comb begin
    logic [SelW-1:0] idx;
    sel   = last_q;
    found = 1'b0;
    for (int i = 1; i <= `CC_NUM_ACC; i++) begin
      idx = last_q + SelW'(i);
      if (!found && acc_port_pvalid_i[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
    // Stalled output keeps its grant
    if (lock_q) begin
      sel = gnt_q;
    end
  end

  assign acc_pvalid_o = acc_port_pvalid_i[sel];
  assign acc_prsp_o   = acc_port_prsp_i[sel];

  always_comb begin
    acc_port_pready_o      = '0;
    acc_port_pready_o[sel] = acc_pready_i & acc_pvalid_o;
  end

  // --------------------------------------------------
  // Pointer and lock
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      // Port 0 gets first priority
      last_q <= SelW'(`CC_NUM_ACC - 1);
      lock_q <= 1'b0;
    end else if (acc_pvalid_o && acc_pready_i) begin
      last_q <= sel;
      lock_q <= 1'b0;
    end else if (acc_pvalid_o) begin
      lock_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_pvalid_o && !lock_q) begin
      gnt_q <= sel;
    end
  end

endmodule

// ==== logic/data_router.sv ====
// Data request router
// Decodes TCDM or SoC target, steers requests and returns responses
// in request order through a small order queue
`timescale 1ns/1ps
`include "cc_route_consts.svh"

module data_router (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`CC_ADDR_WIDTH-1:0] tcdm_base_i,
  // Core side
  input  logic                      data_qvalid_i,
  input  cc_mem_pkg::dreq_t         data_qreq_i,
  output logic                      data_qready_o,
  output logic                      data_pvalid_o,
  output cc_mem_pkg::drsp_t         data_prsp_o,
  input  logic                      data_pready_i,
  // TCDM port
  output logic                      tcdm_qvalid_o,
  output cc_mem_pkg::dreq_t         tcdm_qreq_o,
  input  logic                      tcdm_qready_i,
  input  logic                      tcdm_pvalid_i,
  input  cc_mem_pkg::drsp_t         tcdm_prsp_i,
  output logic                      tcdm_pready_o,
  // SoC port
  output logic                      soc_qvalid_o,
  output cc_mem_pkg::dreq_t         soc_qreq_o,
  input  logic                      soc_qready_i,
  input  logic                      soc_pvalid_i,
  input  cc_mem_pkg::drsp_t         soc_prsp_i,
  output logic                      soc_pready_o
);

  localparam int unsigned AddrW = `CC_ADDR_WIDTH;
  localparam int unsigned PtrW  = $clog2(`CC_RESP_DEPTH);
  localparam int unsigned CntW  = $clog2(`CC_RESP_DEPTH + 1);
  localparam logic [AddrW-1:0] TcdmMask = {AddrW{1'b1}} << `CC_TCDM_ADDR_WIDTH;

  cc_mem_pkg::port_sel_e order_q [`CC_RESP_DEPTH];
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [CntW-1:0]       count_q;

  cc_mem_pkg::port_sel_e req_sel;
  cc_mem_pkg::port_sel_e head;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------
  assign req_sel = ((data_qreq_i.addr & TcdmMask) == (tcdm_base_i & TcdmMask)) ?
                   cc_mem_pkg::PORT_TCDM : cc_mem_pkg::PORT_SOC;

  assign full  = (count_q == CntW'(`CC_RESP_DEPTH));
  assign empty = (count_q == '0);

  assign tcdm_qvalid_o = data_qvalid_i & ~full & (req_sel == cc_mem_pkg::PORT_TCDM);
  assign soc_qvalid_o  = data_qvalid_i & ~full & (req_sel == cc_mem_pkg::PORT_SOC);
  assign tcdm_qreq_o   = data_qreq_i;
  assign soc_qreq_o    = data_qreq_i;

  assign data_qready_o = ~full &
      ((req_sel == cc_mem_pkg::PORT_TCDM) ? tcdm_qready_i : soc_qready_i);
  assign push = data_qvalid_i & data_qready_o;

  // --------------------------------------------------
  // Response side
  // --------------------------------------------------
  // Head of the queue owns the response path
  assign head = order_q[rd_ptr_q];

  assign data_pvalid_o = ~empty &
      ((head == cc_mem_pkg::PORT_TCDM) ? tcdm_pvalid_i : soc_pvalid_i);
  assign data_prsp_o   = (head == cc_mem_pkg::PORT_TCDM) ? tcdm_prsp_i : soc_prsp_i;
  assign tcdm_pready_o = ~empty & (head == cc_mem_pkg::PORT_TCDM) & data_pready_i;
  assign soc_pready_o  = ~empty & (head == cc_mem_pkg::PORT_SOC) & data_pready_i;
  assign pop = data_pvalid_o & data_pready_i;

  // Order queue control
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PtrW'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PtrW'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Order queue storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= req_sel;
    end
  end

endmodule

// ==== logic/cc_route_top.sv ====
// Core complex routing fabric top
// Offload demux, offload response arbiter and data router
`timescale 1ns/1ps
`include "cc_route_consts.svh"

module cc_route_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Offload request from core
  input  logic                                       acc_qvalid_i,
  input  cc_offload_pkg::acc_req_t                   acc_qreq_i,
  output logic                                       acc_qready_o,
  // Offload requests to accelerators
  output logic [`CC_NUM_ACC-1:0]                     acc_port_qvalid_o,
  output cc_offload_pkg::acc_req_t                   acc_port_qreq_o,
  input  logic [`CC_NUM_ACC-1:0]                     acc_port_qready_i,
  // Offload responses from accelerators
  input  logic [`CC_NUM_ACC-1:0]                     acc_port_pvalid_i,
  input  cc_offload_pkg::acc_rsp_t [`CC_NUM_ACC-1:0] acc_port_prsp_i,
  output logic [`CC_NUM_ACC-1:0]                     acc_port_pready_o,
  // Offload response to core
  output logic                                       acc_pvalid_o,
  output cc_offload_pkg::acc_rsp_t                   acc_prsp_o,
  input  logic                                       acc_pready_i,
  // Data path from core
  input  logic [`CC_ADDR_WIDTH-1:0]                  tcdm_base_i,
  input  logic                                       data_qvalid_i,
  input  cc_mem_pkg::dreq_t                          data_qreq_i,
  output logic                                       data_qready_o,
  output logic                                       data_pvalid_o,
  output cc_mem_pkg::drsp_t                          data_prsp_o,
  input  logic                                       data_pready_i,
  // TCDM port
  output logic                                       tcdm_qvalid_o,
  output cc_mem_pkg::dreq_t                          tcdm_qreq_o,
  input  logic                                       tcdm_qready_i,
  input  logic                                       tcdm_pvalid_i,
  input  cc_mem_pkg::drsp_t                          tcdm_prsp_i,
  output logic                                       tcdm_pready_o,
  // SoC port
  output logic                                       soc_qvalid_o,
  output cc_mem_pkg::dreq_t                          soc_qreq_o,
  input  logic                                       soc_qready_i,
  input  logic                                       soc_pvalid_i,
  input  cc_mem_pkg::drsp_t                          soc_prsp_i,
  output logic                                       soc_pready_o
);

  // --------------------------------------------------
  // Offload path
  // --------------------------------------------------
  offload_demux i_offload_demux (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .acc_qvalid_i      ( acc_qvalid_i      ),
    .acc_qreq_i        ( acc_qreq_i        ),
    .acc_qready_o      ( acc_qready_o      ),
    .acc_port_qvalid_o ( acc_port_qvalid_o ),
    .acc_port_qreq_o   ( acc_port_qreq_o   ),
    .acc_port_qready_i ( acc_port_qready_i )
  );

  offload_rsp_arbiter i_offload_rsp_arbiter (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .acc_port_pvalid_i ( acc_port_pvalid_i ),
    .acc_port_prsp_i   ( acc_port_prsp_i   ),
    .acc_port_pready_o ( acc_port_pready_o ),
    .acc_pvalid_o      ( acc_pvalid_o      ),
    .acc_prsp_o        ( acc_prsp_o        ),
    .acc_pready_i      ( acc_pready_i      )
  );

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------
  data_router i_data_router (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .tcdm_base_i   ( tcdm_base_i   ),
    .data_qvalid_i ( data_qvalid_i ),
    .data_qreq_i   ( data_qreq_i   ),
    .data_qready_o ( data_qready_o ),
    .data_pvalid_o ( data_pvalid_o ),
    .data_prsp_o   ( data_prsp_o   ),
    .data_pready_i ( data_pready_i ),
    .tcdm_qvalid_o ( tcdm_qvalid_o ),
    .tcdm_qreq_o   ( tcdm_qreq_o   ),
    .tcdm_qready_i ( tcdm_qready_i ),
    .tcdm_pvalid_i ( tcdm_pvalid_i ),
    .tcdm_prsp_i   ( tcdm_prsp_i   ),
    .tcdm_pready_o ( tcdm_pready_o ),
    .soc_qvalid_o  ( soc_qvalid_o  ),
    .soc_qreq_o    ( soc_qreq_o    ),
    .soc_qready_i  ( soc_qready_i  ),
    .soc_pvalid_i  ( soc_pvalid_i  ),
    .soc_prsp_i    ( soc_prsp_i    ),
    .soc_pready_o  ( soc_pready_o  )
  );

endmodule

// ==== verification/cc_route_sva.sv ====
// Handshake assertions for the routing fabric
// Bound to the data router and the offload response arbiter
`timescale 1ns/1ps
`include "cc_route_consts.svh"

module cc_route_sva (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        valid_i,
  input logic        ready_i,
  input logic [95:0] payload_i,
  input logic [1:0]  port_qfire_i,
  input logic        rsp_fire_i,
  input logic [1:0]  port_valid_i,
  input logic [1:0]  port_ready_i
);

  localparam int unsigned Depth = `CC_RESP_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  // Request order seen at the target ports, bit set for TCDM
  logic [Depth-1:0] tcdm_m;
  logic [PtrW-1:0]  wr_m;
  logic [PtrW-1:0]  rd_m;
  logic [CntW-1:0]  cnt_m;
  logic             push_m;

  assign push_m = |port_qfire_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_m  <= '0;
      rd_m  <= '0;
      cnt_m <= '0;
    end else begin
      if (push_m) begin
        tcdm_m[wr_m] <= port_qfire_i[1];
        wr_m         <= wr_m + PtrW'(1);
      end
      if (rsp_fire_i) begin
        rd_m <= rd_m + PtrW'(1);
      end
      cnt_m <= cnt_m + CntW'(push_m) - CntW'(rsp_fire_i);
    end
  end

  // Stalled transfer keeps valid and payload
  assert property (@(posedge clk_i) disable iff (rst_ni)
    (valid_i && !ready_i) |=> (valid_i && $stable(payload_i)))
    else $error("payload or valid changed while stalled");

  // Outstanding limit blocks the target ports
  assert property (@(posedge clk_i) disable iff (rst_ni)
    (cnt_m == CntW'(Depth)) |-> (port_valid_i == 2'b00))
    else $error("target port valid with the outstanding limit reached");

  // Only the port of the oldest outstanding request may return
  assert property (@(posedge clk_i) disable iff (rst_ni)
    (port_ready_i != 2'b00) |->
      ((cnt_m != '0) && (port_ready_i == (tcdm_m[rd_m] ? 2'b10 : 2'b01))))
    else $error("response port ready out of request order");

endmodule

bind data_router cc_route_sva i_data_sva (
  .clk_i        ( clk_i                                    ),
  .rst_ni       ( rst_ni                                   ),
  .valid_i      ( data_qvalid_i                            ),
  .ready_i      ( data_qready_o                            ),
  .payload_i    ( {27'd0, data_qreq_i}                     ),
  .port_qfire_i ( {tcdm_qvalid_o & tcdm_qready_i,
                   soc_qvalid_o & soc_qready_i}            ),
  .rsp_fire_i   ( data_pvalid_o & data_pready_i            ),
  .port_valid_i ( {tcdm_qvalid_o, soc_qvalid_o}            ),
  .port_ready_i ( {tcdm_pready_o, soc_pready_o}            )
);

bind offload_rsp_arbiter cc_route_sva i_arb_sva (
  .clk_i        ( clk_i                 ),
  .rst_ni       ( rst_ni                ),
  .valid_i      ( acc_pvalid_o          ),
  .ready_i      ( acc_pready_i          ),
  .payload_i    ( {58'd0, acc_prsp_o}   ),
  .port_qfire_i ( 2'b00                 ),
  .rsp_fire_i   ( 1'b0                  ),
  .port_valid_i ( 2'b00                 ),
  .port_ready_i ( 2'b00                 )
);

// ==== verification/cc_route_tb.sv ====
// Routing fabric testbench
// File-driven offload and data cases against unit and memory models
`timescale 1ns/1ps
`include "cc_route_consts.svh"

module cc_route_tb;

  localparam int          MaxCases = 64;
  localparam logic [31:0] TcdmBase = 32'h1000_0000;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic acc_qvalid_i, acc_qready_o, acc_pvalid_o, acc_pready_i;
  cc_offload_pkg::acc_req_t acc_qreq_i, acc_port_qreq_o, unit_req_s;
  cc_offload_pkg::acc_rsp_t acc_prsp_o;
  cc_offload_pkg::acc_rsp_t [3:0] acc_port_prsp_i;
  logic [3:0] acc_port_qvalid_o, acc_port_qready_i, acc_port_pvalid_i, acc_port_pready_o;
  logic [31:0] tcdm_base_i;
  logic data_qvalid_i, data_qready_o, data_pvalid_o, data_pready_i;
  cc_mem_pkg::dreq_t data_qreq_i, tcdm_qreq_o, soc_qreq_o, tcdm_req_s, soc_req_s;
  cc_mem_pkg::drsp_t data_prsp_o, tcdm_prsp_i, soc_prsp_i;
  logic tcdm_qvalid_o, tcdm_qready_i, tcdm_pvalid_i, tcdm_pready_o;
  logic soc_qvalid_o, soc_qready_i, soc_pvalid_i, soc_pready_o;

  // Model state and handshake flags sampled before each rising edge
  logic [3:0]  unit_busy, unit_qfire, unit_pfire;
  int          unit_cnt [4];
  logic        unit_hold, data_hold, slow_soc, burst_stalled;
  logic        tcdm_qfire, tcdm_pfire, soc_qfire, soc_pfire;
  logic [31:0] unit_seed, tcdm_seed, soc_seed;
  int          tcdm_cnt, soc_cnt, outstanding, last_gnt;
  logic [31:0] tcdm_mem [logic [31:0]];
  logic [31:0] soc_mem [logic [31:0]];
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] tcdm_rq [$];
  logic [31:0] soc_rq [$];
  logic [31:0] exp_q [$];
  logic [31:0] cases_mem [0:5*MaxCases-1];
  int          num_cases, errors, checks, offl_sent, offl_rcvd;
  logic        cases_ready;
  event        sampled;

  cc_route_top UUT (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Unwritten memory reads return an address-dependent pattern
  function automatic logic [31:0] fill(input logic [31:0] a);
    return a ^ 32'ha5a5_5a5a;
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill(a);
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // Sampling point 1 ns before each rising edge
  // --------------------------------------------------
  always begin
    @(negedge clk_i);
    #19;
    unit_qfire = acc_port_qvalid_o & acc_port_qready_i;
    unit_pfire = acc_port_pvalid_i & acc_port_pready_o;
    unit_req_s = acc_port_qreq_o;
    tcdm_qfire = tcdm_qvalid_o & tcdm_qready_i;
    tcdm_pfire = tcdm_pvalid_i & tcdm_pready_o;
    soc_qfire  = soc_qvalid_o & soc_qready_i;
    soc_pfire  = soc_pvalid_i & soc_pready_o;
    tcdm_req_s = tcdm_qreq_o;
    soc_req_s  = soc_qreq_o;
    if (!rst_ni) begin
      if (tcdm_qfire || soc_qfire) outstanding++;
      if (data_pvalid_o && data_pready_i) begin
        outstanding--;
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected data response at %0t", $time);
        end else begin
          check("data_prsp_o.data", exp_q.pop_front(), data_prsp_o.data);
        end
      end
      if (outstanding > `CC_RESP_DEPTH) begin
        errors++;
        $display("more than %0d data requests at the target ports at %0t",
                 `CC_RESP_DEPTH, $time);
      end
      if (acc_pvalid_o && acc_pready_i) offl_rcvd++;
    end
    -> sampled;
  end

  // --------------------------------------------------
  // Accelerator units and memories, driven on the falling edge
  // --------------------------------------------------
  assign acc_port_qready_i = ~unit_busy;

  always @(negedge clk_i) begin
    if (rst_ni) begin
      unit_busy = '0;
      acc_port_pvalid_i = '0;
      tcdm_pvalid_i = 1'b0;
      soc_pvalid_i = 1'b0;
      tcdm_rq.delete();
      soc_rq.delete();
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (unit_pfire[k]) begin
          acc_port_pvalid_i[k] = 1'b0;
          unit_busy[k] = 1'b0;
        end
        if (unit_qfire[k]) begin
          unit_seed = lcg(unit_seed);
          unit_cnt[k] = int'(unit_seed[17:16]);
          unit_busy[k] = 1'b1;
          acc_port_prsp_i[k].id = unit_req_s.id;
          acc_port_prsp_i[k].data = unit_req_s.data_arga + 32'(k);
          acc_port_prsp_i[k].error = 1'b0;
        end else if (unit_busy[k] && !acc_port_pvalid_i[k]) begin
          if (unit_cnt[k] > 0) unit_cnt[k]--;
          else if (!unit_hold) acc_port_pvalid_i[k] = 1'b1;
        end
      end
      // TCDM memory
      if (tcdm_pfire) begin
        tcdm_pvalid_i = 1'b0;
        void'(tcdm_rq.pop_front());
        tcdm_seed = lcg(tcdm_seed);
        tcdm_cnt = int'(tcdm_seed[17:16]);
      end
      if (tcdm_qfire) begin
        if (tcdm_req_s.write) begin
          tcdm_mem[tcdm_req_s.addr] = tcdm_req_s.data;
          tcdm_rq.push_back(32'h0);
        end else begin
          tcdm_rq.push_back(tcdm_mem.exists(tcdm_req_s.addr) ?
                            tcdm_mem[tcdm_req_s.addr] : fill(tcdm_req_s.addr));
        end
      end
      if (!tcdm_pvalid_i && tcdm_rq.size() > 0 && !data_hold) begin
        if (tcdm_cnt > 0) tcdm_cnt--;
        else begin
          tcdm_pvalid_i = 1'b1;
          tcdm_prsp_i.data = tcdm_rq[0];
          tcdm_prsp_i.error = 1'b0;
        end
      end
      // SoC memory, slowed during bursts
      if (soc_pfire) begin
        soc_pvalid_i = 1'b0;
        void'(soc_rq.pop_front());
        soc_seed = lcg(soc_seed);
        soc_cnt = slow_soc ? int'(soc_seed[18:16]) + 6 : int'(soc_seed[17:16]);
      end
      if (soc_qfire) begin
        if (soc_req_s.write) begin
          soc_mem[soc_req_s.addr] = soc_req_s.data;
          soc_rq.push_back(32'h0);
        end else begin
          soc_rq.push_back(soc_mem.exists(soc_req_s.addr) ?
                           soc_mem[soc_req_s.addr] : fill(soc_req_s.addr));
        end
      end
      if (!soc_pvalid_i && soc_rq.size() > 0 && !data_hold) begin
        if (soc_cnt > 0) soc_cnt--;
        else begin
          soc_pvalid_i = 1'b1;
          soc_prsp_i.data = soc_rq[0];
          soc_prsp_i.error = 1'b0;
        end
      end
    end
  end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------
  task automatic issue_offload(input int unit, input logic [31:0] id, input logic [31:0] op);
    logic [3:0] onehot;
    onehot = 4'b0001 << unit;
    @(negedge clk_i);
    acc_qvalid_i = 1'b1;
    acc_qreq_i.addr = unit[1:0];
    acc_qreq_i.id = id[4:0];
    acc_qreq_i.data_arga = op;
    acc_qreq_i.data_op = ~op;
    do @(sampled); while (!acc_qready_o);
    check("acc_port_qvalid_o", {28'd0, onehot}, {28'd0, acc_port_qvalid_o});
    check("acc_port_qreq_o.addr", {30'd0, unit[1:0]}, {30'd0, acc_port_qreq_o.addr});
    check("acc_port_qreq_o.id", {27'd0, id[4:0]}, {27'd0, acc_port_qreq_o.id});
    check("acc_port_qreq_o.data_arga", op, acc_port_qreq_o.data_arga);
    check("acc_port_qreq_o.data_op", ~op, acc_port_qreq_o.data_op);
    offl_sent++;
    @(negedge clk_i);
    acc_qvalid_i = 1'b0;
  endtask

  task automatic wait_offload_rsp(input logic [31:0] id, input logic [31:0] data);
    do @(sampled); while (!(acc_pvalid_o && acc_pready_i));
    check("acc_prsp_o.id", {27'd0, id[4:0]}, {27'd0, acc_prsp_o.id});
    check("acc_prsp_o.data", data, acc_prsp_o.data);
  endtask

  // All four units answer in the same cycle
  task automatic run_round_robin(input logic [31:0] idb, input logic [31:0] opb);
    int p;
    unit_hold = 1'b1;
    for (int k = 0; k < 4; k++) issue_offload(k, idb + 32'(k), opb + 32'(16 * k));
    do @(sampled); while (unit_busy != 4'hf);
    repeat (4) @(sampled);
    @(negedge clk_i);
    unit_hold = 1'b0;
    // Core stalls the merged response for a few cycles
    acc_pready_i = 1'b0;
    repeat (3) @(negedge clk_i);
    acc_pready_i = 1'b1;
    for (int j = 0; j < 4; j++) begin
      p = (last_gnt + 1 + j) % 4;
      wait_offload_rsp(idb + 32'(p), opb + 32'(17 * p));
    end
    last_gnt = p;
  endtask

  task automatic issue_data(input logic [31:0] addr, input logic wr,
                            input logic [31:0] wdata, input logic [31:0] exp);
    logic exp_tcdm;
    int   stall;
    exp_tcdm = (addr[31:`CC_TCDM_ADDR_WIDTH] == TcdmBase[31:`CC_TCDM_ADDR_WIDTH]);
    stall = 0;
    @(negedge clk_i);
    data_qvalid_i = 1'b1;
    data_qreq_i.addr = addr;
    data_qreq_i.write = wr;
    data_qreq_i.data = wdata;
    data_qreq_i.strb = 4'hf;
    @(sampled);
    while (!data_qready_o) begin
      stall++;
      // Held responses keep the queue full until released here
      if (stall == 8 && data_hold) begin
        check("outstanding", 32'(`CC_RESP_DEPTH), 32'(outstanding));
        burst_stalled = 1'b1;
        data_hold = 1'b0;
      end
      @(sampled);
    end
    check("tcdm_qvalid_o", {31'd0, exp_tcdm}, {31'd0, tcdm_qvalid_o});
    check("soc_qvalid_o", {31'd0, !exp_tcdm}, {31'd0, soc_qvalid_o});
    if (exp_tcdm) begin
      check("tcdm_qreq_o.addr", addr, tcdm_qreq_o.addr);
      check("tcdm_qreq_o.data", wdata, tcdm_qreq_o.data);
    end else begin
      check("soc_qreq_o.addr", addr, soc_qreq_o.addr);
      check("soc_qreq_o.data", wdata, soc_qreq_o.data);
    end
    exp_q.push_back(exp);
    @(negedge clk_i);
    data_qvalid_i = 1'b0;
  endtask

  // Alternating TCDM and SoC loads with responses withheld at first
  task automatic run_burst(input logic [31:0] base, input int n);
    logic [31:0] addr;
    burst_stalled = 1'b0;
    data_hold = 1'b1;
    slow_soc = 1'b1;
    for (int i = 0; i < n; i++) begin
      if (i % 2 == 0) addr = base + 32'(4 * i);
      else addr = {16'h8000, base[15:0]} + 32'(4 * i);
      issue_data(addr, 1'b0, 32'h0, ref_read(addr));
    end
    data_hold = 1'b0;
    if (n > `CC_RESP_DEPTH && !burst_stalled) begin
      errors++;
      $display("burst of %0d requests was never held at the outstanding limit", n);
    end
    while (exp_q.size() > 0) @(sampled);
    slow_soc = 1'b0;
  endtask

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  initial begin
    wait (cases_ready);
    repeat (num_cases * 200 + 10) @(posedge clk_i);
    $display("timeout: cases did not finish within %0d cycles", num_cases * 200 + 10);
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rst_ni = 1'b1;
    acc_qvalid_i = 1'b0;
    acc_qreq_i = '0;
    acc_pready_i = 1'b1;
    tcdm_base_i = TcdmBase;
    data_qvalid_i = 1'b0;
    data_qreq_i = '0;
    data_pready_i = 1'b1;
    tcdm_qready_i = 1'b1;
    soc_qready_i = 1'b1;
    unit_busy = '0;
    acc_port_pvalid_i = '0;
    tcdm_pvalid_i = 1'b0;
    soc_pvalid_i = 1'b0;
    acc_port_prsp_i = '0;
    tcdm_prsp_i = '0;
    soc_prsp_i = '0;
    unit_hold = 1'b0;
    data_hold = 1'b0;
    slow_soc = 1'b0;
    unit_seed = 32'h27d4c952;
    tcdm_seed = 32'h27d4c952 ^ 32'h0000_1111;
    soc_seed = 32'h27d4c952 ^ 32'h0000_2222;
    last_gnt = 3;
    cases_ready = 1'b0;
    $readmemh("verification/cc_route_cases.txt", cases_mem);
    num_cases = 0;
    while (num_cases < MaxCases && !$isunknown(cases_mem[5 * num_cases]) &&
           cases_mem[5 * num_cases] != 32'd0) num_cases++;
    cases_ready = 1'b1;

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (3) begin
      @(sampled);
      check("acc_port_qvalid_o", 32'd0, {28'd0, acc_port_qvalid_o});
      check("acc_pvalid_o", 32'd0, {31'd0, acc_pvalid_o});
      check("data_pvalid_o", 32'd0, {31'd0, data_pvalid_o});
      check("tcdm_qvalid_o", 32'd0, {31'd0, tcdm_qvalid_o});
      check("soc_qvalid_o", 32'd0, {31'd0, soc_qvalid_o});
    end

    for (int c = 0; c < num_cases; c++) begin
      case (cases_mem[5 * c])
        32'd1: begin
          issue_offload(int'(cases_mem[5 * c + 1]), cases_mem[5 * c + 2], cases_mem[5 * c + 3]);
          wait_offload_rsp(cases_mem[5 * c + 2], cases_mem[5 * c + 4]);
          last_gnt = int'(cases_mem[5 * c + 1]);
        end
        32'd2: begin
          ref_mem[cases_mem[5 * c + 1]] = cases_mem[5 * c + 3];
          issue_data(cases_mem[5 * c + 1], 1'b1, cases_mem[5 * c + 3], cases_mem[5 * c + 4]);
        end
        32'd3: issue_data(cases_mem[5 * c + 1], 1'b0, 32'h0, cases_mem[5 * c + 4]);
        32'd4: run_burst(cases_mem[5 * c + 1], int'(cases_mem[5 * c + 2]));
        32'd5: run_round_robin(cases_mem[5 * c + 2], cases_mem[5 * c + 3]);
        default: begin
          errors++;
          $display("case %0d has an unknown kind %h", c, cases_mem[5 * c]);
        end
      endcase
    end

    while (exp_q.size() > 0) @(sampled);
    repeat (4) @(sampled);
    check("offload responses", 32'(offl_sent), 32'(offl_rcvd));
    $display("cases: %0d, checks: %0d, errors: %0d", num_cases, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== cc_route.f ====
+incdir+include
logic/cc_offload_pkg.sv
logic/cc_mem_pkg.sv
logic/offload_demux.sv
logic/offload_rsp_arbiter.sv
logic/data_router.sv
logic/cc_route_top.sv
verification/cc_route_sva.sv
verification/cc_route_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the routing fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f cc_route.f \
  --top-module cc_route_tb \
  --Mdir build \
  -o cc_route_sim

./build/cc_route_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  exit 1
fi
exit 0

// ==== verification/cc_route_cases.txt ====
// kind addr_or_unit id data expected
// kind 1 offload, 2 store, 3 load, 4 burst (id is count), 5 round robin
1 00000000 00000001 00000100 00000100
1 00000001 00000002 00000200 00000201
1 00000002 00000003 00000300 00000302
1 00000003 00000004 00000400 00000403
2 10000010 00000000 cafe0001 00000000
2 80000020 00000000 beef0002 00000000
3 10000010 00000000 00000000 cafe0001
3 80000020 00000000 00000000 beef0002
3 10000044 00000000 00000000 b5a55a1e
2 1001fffc 00000000 12345678 00000000
3 1001fffc 00000000 00000000 12345678
2 10020000 00000000 0badf00d 00000000
3 10020000 00000000 00000000 0badf00d
5 00000000 00000008 00001000 00000000
1 00000002 00000005 00000010 00000012
4 10000100 00000006 00000000 00000000
4 10000200 00000008 00000000 00000000
2 80000020 00000000 11111111 00000000
3 80000020 00000000 00000000 11111111
5 00000000 00000010 00002000 00000000
